// ==== Bender.yml ====
package:
  name: decode_front_end

sources:
  - files:
      - src/axiLitePkg.sv
      - src/rvIsaPkg.sv
      - src/fetchUnit.sv
      - src/syncQueue.sv
      - src/controlUnit.sv
      - src/decodeFrontEnd.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tbDecodeFrontEnd.sv

// ==== sources.f ====
+incdir+test
src/axiLitePkg.sv
src/rvIsaPkg.sv
src/fetchUnit.sv
src/syncQueue.sv
src/controlUnit.sv
src/decodeFrontEnd.sv
test/tbDecodeFrontEnd.sv

// ==== src/axiLitePkg.sv ====
package axiLitePkg;

    ////////////////////////////////////////
    // Channel widths
    ////////////////////////////////////////

    localparam int axiAddrW = 32;
    localparam int axiDataW = 32;

    // Unprivileged, secure, data access
    localparam logic [2:0] axiProtDefault = 3'b000;

    ////////////////////////////////////////
    // Response codes
    ////////////////////////////////////////

    typedef logic [1:0] axiRespT;

    localparam axiRespT OKAY   = 2'b00;
    localparam axiRespT SLVERR = 2'b10; // Slave error

    ////////////////////////////////////////
    // Read channel payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic [axiAddrW-1:0] addr;
        logic [2:0]          prot;
    } axiArT; // 35 bits

    typedef struct packed {
        logic [axiDataW-1:0] data;
        axiRespT             resp;
    } axiRT; // 34 bits

endpackage

// ==== src/controlUnit.sv ====
module controlUnit (
    input  rvIsaPkg::fetchEntryT   headEntry,
    input  logic                   iqEmpty,
    output logic                   iqPop,
    output rvIsaPkg::decodedInstrT decEntry,
    output logic                   oqPush,
    input  logic                   oqFull
);

    import rvIsaPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic  isImm;
    logic  shiftOp;
    logic  f7Alt;
    logic  f7Ok;
    aluOpT aluOp;
    wbSelT aluWb;
    logic  aluKnown;
    logic  legal;
    ctrlT  ctrl;

    assign opcode = headEntry.instr[6:0];
    assign funct3 = headEntry.instr[14:12];
    assign funct7 = headEntry.instr[31:25];

    ////////////////////////////////////////
    // ALU operation for OP and OPIMM
    ////////////////////////////////////////

    assign isImm   = (opcode == OPIMM);
    assign shiftOp = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign f7Alt   = (funct7 == F7ALT);
    // Immediate forms only look at funct7 for shifts
    assign f7Ok    = (funct7 == F7BASE) || (isImm && !shiftOp);

    always_comb
    begin
        aluOp    = ADD;
        aluWb    = ALU;
        aluKnown = f7Ok;
        case (funct3)
            3'b000:
            begin
                if (f7Alt && !isImm)
                begin
                    aluOp    = SUB; // No SUBI in RV32I
                    aluKnown = 1'b1;
                end
            end
            3'b001: aluOp = SLL;
            3'b010, 3'b011:
            begin
                aluOp = SUB; // SLT and SLTU compare by subtraction
                aluWb = CMP;
            end
            3'b100: aluOp = XOR;
            3'b101:
            begin
                if (f7Alt)
                begin
                    aluOp    = SRA;
                    aluKnown = 1'b1;
                end
                else
                    aluOp = SRL;
            end
            3'b110: aluOp = OR;
            default: aluOp = AND;
        endcase
    end

    ////////////////////////////////////////
    // Control word
    ////////////////////////////////////////

    always_comb
    begin
        ctrl  = '0;
        legal = 1'b1;
        case (opcode)
            OP, OPIMM:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluOp;
                ctrl.aluSrc   = isImm;
                ctrl.memSize  = WORD;
                ctrl.signExt  = 1'b1;
                ctrl.wbSel    = aluWb;
                legal         = aluKnown;
            end
            LOAD:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1; // Base plus offset
                ctrl.wbSel    = ALU;
                ctrl.signExt  = !funct3[2]; // LBU and LHU zero-extend
                case (funct3)
                    3'b000, 3'b100: ctrl.memSize = BYTE;
                    3'b001, 3'b101: ctrl.memSize = HALF;
                    3'b010:         ctrl.memSize = WORD;
                    default:        legal = 1'b0;
                endcase
            end
            STORE:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.wbSel    = ALU;
                case (funct3)
                    3'b000:  ctrl.memSize = BYTE;
                    3'b001:  ctrl.memSize = HALF;
                    3'b010:  ctrl.memSize = WORD;
                    default: legal = 1'b0;
                endcase
            end
            BRANCH:
            begin
                ctrl.branch  = 1'b1;
                ctrl.aluCtrl = SUB;
                ctrl.memSize = WORD;
                ctrl.signExt = (funct3[2:1] != 2'b11); // BLTU and BGEU unsigned
                legal        = (funct3[2:1] != 2'b01); // 010 and 011 unused
            end
            JAL, JALR:
            begin
                ctrl.jump    = 1'b1;
                ctrl.memSize = WORD;
                ctrl.signExt = 1'b1;
                legal        = (opcode == JAL) || (funct3 == 3'b000);
            end
            LUI, AUIPC:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = (opcode == LUI) ? PASSB : ADD; // AUIPC adds pc
                ctrl.aluSrc   = 1'b1;
                ctrl.memSize  = WORD;
                ctrl.signExt  = 1'b1;
                ctrl.wbSel    = ALU;
            end
            default: legal = 1'b0;
        endcase

        if (!legal || headEntry.fetchErr)
        begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

    // Move one word per cycle when there is room
    assign iqPop    = !iqEmpty && !oqFull;
    assign oqPush   = iqPop;
    assign decEntry = '{pc: headEntry.pc, instr: headEntry.instr, ctrl: ctrl};

endmodule

// ==== src/decodeFrontEnd.sv ====
module decodeFrontEnd (
    input  logic                   clk,
    input  logic                   rstN,
    // Instruction memory read port
    output axiLitePkg::axiArT      arOut,
    output logic                   arValid,
    input  logic                   arReady,
    input  axiLitePkg::axiRT       rIn,
    input  logic                   rValid,
    output logic                   rReady,
    // Decoded stream
    output rvIsaPkg::decodedInstrT decOut,
    output logic                   decValid,
    input  logic                   decReady
);

    import rvIsaPkg::*;

    fetchEntryT   iqPushEntry;
    logic         iqPush;
    logic         iqFull;
    fetchEntryT   iqHead;
    logic         iqEmpty;
    logic         iqPop;
    decodedInstrT oqPushEntry;
    logic         oqPush;
    logic         oqFull;
    logic         oqEmpty;

    fetchUnit fetchUnit0 (
        .clk(clk), .rstN(rstN),
        .arOut(arOut), .arValid(arValid), .arReady(arReady),
        .rIn(rIn), .rValid(rValid), .rReady(rReady),
        .pushEntry(iqPushEntry), .push(iqPush), .full(iqFull)
    );

    syncQueue #(.payloadT(fetchEntryT), .depth(iqDepth)) iq0 (
        .clk(clk), .rstN(rstN),
        .push(iqPush), .wrData(iqPushEntry), .full(iqFull),
        .pop(iqPop), .rdData(iqHead), .empty(iqEmpty)
    );

    controlUnit controlUnit0 (
        .headEntry(iqHead), .iqEmpty(iqEmpty), .iqPop(iqPop),
        .decEntry(oqPushEntry), .oqPush(oqPush), .oqFull(oqFull)
    );

    syncQueue #(.payloadT(decodedInstrT), .depth(oqDepth)) oq0 (
        .clk(clk), .rstN(rstN),
        .push(oqPush), .wrData(oqPushEntry), .full(oqFull),
        .pop(decValid && decReady), .rdData(decOut), .empty(oqEmpty)
    );

    assign decValid = !oqEmpty; // Output handshake

endmodule

// ==== src/fetchUnit.sv ====
module fetchUnit (
    input  logic                   clk,
    input  logic                   rstN,
    // AXI4-Lite read address
    output axiLitePkg::axiArT      arOut,
    output logic                   arValid,
    input  logic                   arReady,
    // AXI4-Lite read data
    input  axiLitePkg::axiRT       rIn,
    input  logic                   rValid,
    output logic                   rReady,
    // Instruction queue write side
    output rvIsaPkg::fetchEntryT   pushEntry,
    output logic                   push,
    input  logic                   full
);

    import axiLitePkg::*;

    logic [axiAddrW-1:0] pc;
    logic                outstanding; // AR accepted, R not yet seen
    logic                arFire;
    logic                rFire;

    assign arFire = arValid && arReady;
    assign rFire  = rValid && rReady;

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////

    // pc only moves on the R handshake, so the address is stable while arValid waits
    assign arOut = '{addr: pc, prot: axiProtDefault};

    assign rReady = outstanding && !full; // Full queue stalls the response

    ////////////////////////////////////////
    // Queue side
    ////////////////////////////////////////

    assign push      = rFire;
    assign pushEntry = '{pc: pc, instr: rIn.data, fetchErr: (rIn.resp != OKAY)};

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc          <= '0;
            arValid     <= 1'b0;
            outstanding <= 1'b0;
        end
        else
        begin
            if (arFire)
            begin
                arValid     <= 1'b0;
                outstanding <= 1'b1;
            end
            else if (!arValid && !outstanding && !full)
                arValid <= 1'b1; // One read in flight at most

            if (rFire)
            begin
                outstanding <= 1'b0;
                pc          <= pc + axiAddrW'(4); // Sequential fetch only
            end
        end
    end

endmodule

// ==== src/rvIsaPkg.sv ====
package rvIsaPkg;

    localparam int xLen = 32;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////

    localparam logic [6:0] OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPIMM  = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;

    // funct7 variants
    localparam logic [6:0] F7BASE = 7'b0000000;
    localparam logic [6:0] F7ALT  = 7'b0100000; // SUB and SRA

    ////////////////////////////////////////
    // Control field encodings
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        ADD   = 4'b0000,
        SUB   = 4'b0001,
        AND   = 4'b0010,
        OR    = 4'b0100,
        XOR   = 4'b1000,
        SRL   = 4'b1001,
        SLL   = 4'b1010,
        SRA   = 4'b1100,
        PASSB = 4'b1101  // Operand B straight through for LUI
    } aluOpT;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memSizeT;

    typedef enum logic [1:0] {
        CMP = 2'b00, // Set-less-than result
        ALU = 2'b01
    } wbSelT;

    ////////////////////////////////////////
    // Queue payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic [xLen-1:0] pc;
        logic [xLen-1:0] instr;
        logic            fetchErr; // Bus returned a non-OKAY response
    } fetchEntryT; // 65 bits

    typedef struct packed {
        logic    regWrite;
        aluOpT   aluCtrl;
        logic    memWrite;
        logic    memToReg;
        logic    aluSrc;   // Immediate as operand B
        memSizeT memSize;
        logic    signExt;
        wbSelT   wbSel;
        logic    branch;
        logic    jump;
        logic    illegal;
    } ctrlT; // 16 bits

    typedef struct packed {
        logic [xLen-1:0] pc;
        logic [xLen-1:0] instr;
        ctrlT            ctrl;
    } decodedInstrT; // 80 bits

    localparam int iqDepth = 4;
    localparam int oqDepth = 2;

endpackage

// ==== src/syncQueue.sv ====
module syncQueue #(
    parameter type payloadT = logic,
    parameter int  depth    = 4
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    push,
    input  payloadT wrData,
    output logic    full,
    input  logic    pop,
    output payloadT rdData,
    output logic    empty
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payloadT         mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;

    assign full   = (count == cntW'(depth));
    assign empty  = (count == '0);
    assign rdData = mem[rdPtr]; // Head always on the output

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wrPtr] <= wrData;
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1; // Wrap for any depth
            if (pop)
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

// ==== test/decodeRef.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected control word from the RV32I decode table
function automatic ctrlT decodeRef(logic [31:0] instr, logic fetchErr);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       imm;
    logic       base;
    logic       ok;
    ctrlT       c;
    opc  = instr[6:0];
    f3   = instr[14:12];
    f7   = instr[31:25];
    imm  = (opc == OPIMM);
    base = (f7 == F7BASE);
    ok   = 1'b1;
    c    = '0; // ADD, BYTE and CMP are all zero
    case (opc)
        OP, OPIMM:
        begin
            c.regWrite = 1'b1;
            c.aluSrc   = imm;
            c.memSize  = WORD;
            c.signExt  = 1'b1;
            c.wbSel    = ALU;
            ok         = imm || base; // Register forms need the base funct7
            case (f3)
                3'b000:
                begin
                    if (!imm && f7 == F7ALT)
                    begin
                        c.aluCtrl = SUB;
                        ok        = 1'b1;
                    end
                end
                3'b001:
                begin
                    c.aluCtrl = SLL;
                    ok        = base;
                end
                3'b010, 3'b011:
                begin
                    c.aluCtrl = SUB; // SLT and SLTU
                    c.wbSel   = CMP;
                end
                3'b100: c.aluCtrl = XOR;
                3'b101:
                begin
                    c.aluCtrl = (f7 == F7ALT) ? SRA : SRL;
                    ok        = base || (f7 == F7ALT);
                end
                3'b110: c.aluCtrl = OR;
                default: c.aluCtrl = AND;
            endcase
        end
        LOAD:
        begin
            c.regWrite = 1'b1;
            c.memToReg = 1'b1;
            c.aluSrc   = 1'b1;
            c.wbSel    = ALU;
            c.signExt  = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b010);
            case (f3)
                3'b000, 3'b100: c.memSize = BYTE;
                3'b001, 3'b101: c.memSize = HALF;
                3'b010:         c.memSize = WORD;
                default:        ok = 1'b0;
            endcase
        end
        STORE:
        begin
            c.memWrite = 1'b1;
            c.aluSrc   = 1'b1;
            c.signExt  = 1'b1;
            c.wbSel    = ALU;
            case (f3)
                3'b000:  c.memSize = BYTE;
                3'b001:  c.memSize = HALF;
                3'b010:  c.memSize = WORD;
                default: ok = 1'b0;
            endcase
        end
        BRANCH:
        begin
            c.branch  = 1'b1;
            c.aluCtrl = SUB;
            c.memSize = WORD;
            case (f3)
                3'b000, 3'b001, 3'b100, 3'b101: c.signExt = 1'b1;
                3'b110, 3'b111:                 c.signExt = 1'b0; // Unsigned compares
                default:                        ok = 1'b0;
            endcase
        end
        JAL, JALR:
        begin
            c.jump    = 1'b1;
            c.memSize = WORD;
            c.signExt = 1'b1;
            if (opc == JALR)
                ok = (f3 == 3'b000);
        end
        LUI, AUIPC:
        begin
            c.regWrite = 1'b1;
            c.aluCtrl  = (opc == LUI) ? PASSB : ADD;
            c.aluSrc   = 1'b1;
            c.memSize  = WORD;
            c.signExt  = 1'b1;
            c.wbSel    = ALU;
        end
        default: ok = 1'b0;
    endcase
    if (!ok || fetchErr)
    begin
        c         = '0;
        c.illegal = 1'b1;
    end
    return c;
endfunction

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsrStep(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One step per bit taken
function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsrState = lfsrStep(lfsrState);
        v         = {v[30:0], lfsrState[0]};
    end
    return v;
endfunction

`endif

// ==== test/tbDecodeFrontEnd.sv ====
module tbDecodeFrontEnd;

    timeunit 1ns;
    timeprecision 100ps;

    import axiLitePkg::*;
    import rvIsaPkg::*;

    localparam int numWords    = 64;
    localparam int errIdx      = 37;  // Word fetched with SLVERR
    localparam int waitLimit   = 300; // Cycles per wait
    localparam int stallCycles = 120; // Output held off at start

    logic         clk;
    logic         rstN;
    axiArT        arOut;
    logic         arValid;
    logic         arReady;
    axiRT         rIn;
    logic         rValid;
    logic         rReady;
    decodedInstrT decOut;
    logic         decValid;
    logic         decReady;

    logic [15:0] lfsrState;
    logic [31:0] prog [numWords];
    int          arDelay [numWords];
    int          rDelay [numWords];
    logic        readyBits [256];
    int          arCount;
    int          checkCount;
    int          errorCount;
    int          failCount;

    `include "decodeRef.svh"

    decodeFrontEnd dut0 (
        .clk(clk), .rstN(rstN),
        .arOut(arOut), .arValid(arValid), .arReady(arReady),
        .rIn(rIn), .rValid(rValid), .rReady(rReady),
        .decOut(decOut), .decValid(decValid), .decReady(decReady)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (rstN && arValid && arReady)
            arCount <= arCount + 1; // AR handshakes seen
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic compareFlag(string name, logic got, logic exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareAr(axiArT got, axiArT exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("ERROR arOut got %h expected %h", got, exp);
        end
    endtask

    task automatic compareCtrl(ctrlT got, ctrlT exp, logic [31:0] instr);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("ERROR decOut.ctrl got %h expected %h for instr %h", got, exp, instr);
        end
    endtask

    task automatic compareDecoded(decodedInstrT got, decodedInstrT exp);
        checkCount++;
        if (got.pc !== exp.pc)
        begin
            errorCount++;
            $display("ERROR decOut.pc got %h expected %h", got.pc, exp.pc);
        end
        if (got.instr !== exp.instr)
        begin
            errorCount++;
            $display("ERROR decOut.instr got %h expected %h", got.instr, exp.instr);
        end
        compareCtrl(got.ctrl, exp.ctrl, exp.instr);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic logic [6:0] pickOpcode(int cat);
        case (cat)
            0:       return OP;
            1:       return OPIMM;
            2:       return LOAD;
            3:       return STORE;
            4:       return BRANCH;
            5:       return JAL;
            6:       return JALR;
            7:       return LUI;
            default: return AUIPC;
        endcase
    endfunction

    task automatic buildProgram();
        int          cat;
        logic [6:0]  f7;
        logic [1:0]  f7Sel;
        for (int i = 0; i < numWords; i++)
        begin
            cat = randBits(4) % 11; // 9 and 10 give junk
            if (cat > 8)
                prog[i] = randBits(32);
            else
            begin
                f7Sel = 2'(randBits(2));
                f7    = (f7Sel == 2'd2) ? F7ALT : (f7Sel == 2'd3) ? 7'(randBits(7)) : F7BASE;
                prog[i] = {f7, 10'(randBits(10)), 3'(randBits(3)), 5'(randBits(5)),
                           pickOpcode(cat)};
            end
            arDelay[i] = randBits(2);
            rDelay[i]  = randBits(2);
        end
        for (int i = 0; i < 256; i++)
            readyBits[i] = 1'(randBits(1));
    endtask

    task automatic checkSingleRead();
        if (arValid)
        begin
            failCount++;
            $display("A second read address was issued before the previous read response");
        end
    endtask

    // AXI4-Lite memory with random delays
    task automatic serveReads();
        int    waited;
        axiArT expAr;
        for (int k = 0; k < numWords; k++)
        begin
            expAr  = '{addr: 32'(k * 4), prot: 3'b000};
            waited = 0;
            while (!arValid)
            begin
                @(negedge clk);
                waited++;
                if (waited > waitLimit)
                begin
                    failCount++;
                    $display("Timed out waiting for the read address of word %0d", k);
                    return;
                end
            end
            compareAr(arOut, expAr);
            repeat (arDelay[k])
            begin
                @(negedge clk);
                compareFlag("arValid", arValid, 1'b1); // Must hold until accepted
                compareAr(arOut, expAr);
            end
            arReady = 1'b1;
            @(negedge clk);
            arReady = 1'b0;
            repeat (rDelay[k])
            begin
                @(negedge clk);
                checkSingleRead();
            end
            rIn    = '{data: prog[k], resp: (k == errIdx) ? SLVERR : OKAY};
            rValid = 1'b1;
            waited = 0;
            while (!rReady)
            begin
                @(negedge clk);
                checkSingleRead();
                waited++;
                if (waited > waitLimit)
                begin
                    failCount++;
                    $display("Timed out waiting for the fetch unit to accept word %0d", k);
                    return;
                end
            end
            @(negedge clk); // Handshake on the edge before
            rValid = 1'b0;
            rIn    = '0;
        end
    endtask

    // Drives decReady and checks every output handshake in order
    task automatic drainAndCheck();
        int           idx;
        int           cycle;
        int           idle;
        int           arAtMark;
        decodedInstrT expEntry;
        idx      = 0;
        cycle    = 0;
        idle     = 0;
        arAtMark = 0;
        while (idx < numWords)
        begin
            @(negedge clk);
            cycle++;
            idle++;
            decReady = (cycle <= stallCycles) ? 1'b0 : readyBits[cycle % 256];
            if (cycle == stallCycles - 20)
                arAtMark = arCount;
            if (cycle == stallCycles)
            begin
                if (arCount != arAtMark || arCount > iqDepth + oqDepth + 1)
                begin
                    failCount++;
                    $display("Read addresses kept issuing while the output was stalled");
                end
            end
            if (decValid && decReady)
            begin
                expEntry = '{pc: 32'(idx * 4), instr: prog[idx],
                             ctrl: decodeRef(prog[idx], idx == errIdx)};
                compareDecoded(decOut, expEntry);
                idx++;
                idle = 0;
            end
            if (idle > waitLimit)
            begin
                failCount++;
                $display("Timed out waiting for decoded word %0d", idx);
                return;
            end
        end
        @(negedge clk); // Last word leaves on the edge before
        decReady = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            if (decValid)
            begin
                failCount++;
                $display("A decoded word appeared after the last program word");
                return;
            end
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rstN       = 1'b0;
        arReady    = 1'b0;
        rIn        = '0;
        rValid     = 1'b0;
        decReady   = 1'b0;
        arCount    = 0;
        checkCount = 0;
        errorCount = 0;
        failCount  = 0;
        lfsrState  = 16'd32172;
        buildProgram();

        repeat (3)
        begin
            @(negedge clk);
            compareFlag("arValid", arValid, 1'b0);
            compareFlag("rReady", rReady, 1'b0);
            compareFlag("decValid", decValid, 1'b0);
        end
        rstN = 1'b1;
        @(negedge clk);
        compareFlag("rReady", rReady, 1'b0); // Nothing accepted on AR yet
        compareFlag("decValid", decValid, 1'b0);

        fork
            serveReads();
            drainAndCheck();
        join

        $display("Checks %0d, value errors %0d, other failures %0d",
                 checkCount, errorCount, failCount);
        if (errorCount == 0 && failCount == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
